// ==== logic/codec_intl_cfg_pkg.sv ====
// Size constants only; block address width must stay within cMAX_ADDR_W (4096 symbols max)

package codec_intl_cfg_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Symbol format
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int cSYM_W = 8;        // Data bits per symbol

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Default block geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Symbols are written row by row and read column by column,
  // so a block is cDEF_ROWS x cDEF_COLS symbols deep.
  localparam int cDEF_ROWS = 8;     // Rows per block
  localparam int cDEF_COLS = 16;    // Columns per block

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Address limits
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Command buses carry addresses at this width.
  // Each module slices down to the width its geometry needs.
  localparam int cMAX_ADDR_W = 12;  // Widest block address supported

endpackage

// ==== logic/codec_intl_types_pkg.sv ====
// Traffic and control types; all address fields are cMAX_ADDR_W wide, upper bits unused

package codec_intl_types_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Symbol stream
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic                                  val;   // One-cycle symbol strobe
    logic                                  sop;   // First symbol of a block
    logic                                  eop;   // Last symbol of a block
    logic [codec_intl_cfg_pkg::cSYM_W-1:0] data;  // Symbol payload
  } intl_sym_t;                                   // 11 bits

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bank handoff and memory commands
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic done;                                   // Block finished, one cycle
    logic bank;                                   // Bank that was filled
  } bank_evt_t;                                   // 2 bits

  typedef struct packed {
    logic                                       wr;    // Write strobe
    logic                                       bank;  // Target bank
    logic [codec_intl_cfg_pkg::cMAX_ADDR_W-1:0] addr;  // Row-major slot
    logic [codec_intl_cfg_pkg::cSYM_W-1:0]      data;  // Symbol to store
  } wr_cmd_t;                                          // 22 bits

  typedef struct packed {
    logic                                       rd;    // Read strobe
    logic                                       bank;  // Source bank
    logic [codec_intl_cfg_pkg::cMAX_ADDR_W-1:0] addr;  // Column-major slot
    logic                                       sop;   // First read of burst
    logic                                       eop;   // Last read of burst
  } rd_cmd_t;                                          // 16 bits

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read scheduler
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic {
    RD_IDLE  = 1'b0,                              // Waiting for a full bank
    RD_BURST = 1'b1                               // Reading a bank out
  } rd_state_t;

endpackage

// ==== logic/codec_mem_block.sv ====
// Read-first simple dual-port RAM; read latency is 1 + pPIPE enabled edges, writes blocked in reset
`timescale 1ns/100ps

module codec_mem_block #(
  parameter int pADDR_W = 8,              // Address bits
  parameter int pDAT_W  = 8,              // Word width
  parameter bit pPIPE   = 1               // Extra output register
) (
  input  logic              iclk,
  input  logic              reset,
  input  logic              clkena,       // Gates both ports
  input  logic              write,        // Write strobe
  input  logic [pADDR_W-1:0] waddr,
  input  logic [pDAT_W-1:0]  wdat,
  input  logic [pADDR_W-1:0] raddr,
  output logic [pDAT_W-1:0]  rdat
);

  logic [pDAT_W-1:0] mem [2**pADDR_W];    // Storage array
  logic [pDAT_W-1:0] rd_pipe [2];         // Read register and pipe stage

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Storage and read path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge iclk) begin
    if (clkena) begin
      rd_pipe[0] <= mem[raddr];           // Old data on same-address write
      rd_pipe[1] <= rd_pipe[0];           // Second stage, used with pPIPE
      if (write && !reset) begin
        mem[waddr] <= wdat;
      end
    end
  end

  assign rdat = rd_pipe[pPIPE];           // Stage select by pipeline option

endmodule

// ==== logic/intl_write_ctrl.sv ====
// Row-major writer; every block must start with sop, no back-pressure toward the source
`timescale 1ns/100ps

module intl_write_ctrl #(
  parameter int pROWS = 8,                            // Rows per block
  parameter int pCOLS = 16                            // Columns per block
) (
  input  logic                            iclk,
  input  logic                            reset,
  input  codec_intl_types_pkg::intl_sym_t in_sym,     // Input symbol stream
  output codec_intl_types_pkg::wr_cmd_t   wr_cmd,     // Memory write request
  output codec_intl_types_pkg::bank_evt_t bank_evt    // End of block event
);

  localparam int cAW     = codec_intl_cfg_pkg::cMAX_ADDR_W;
  localparam int cBLK    = pROWS * pCOLS;             // Symbols per block
  localparam int cADDR_W = (cBLK > 1) ? $clog2(cBLK) : 1;

  logic [cADDR_W-1:0] cnt;       // Next row-major slot
  logic [cADDR_W-1:0] waddr;     // Slot for the current symbol
  logic               blk_last;  // Current symbol closes the block
  logic               wr_bank;   // Bank being filled
  logic               in_blk;    // A sop has been seen since reset

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Slot counter
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign waddr    = in_sym.sop ? '0 : cnt;                    // sop restarts at slot 0
  assign blk_last = in_sym.val & (waddr == cADDR_W'(cBLK - 1));

  always_ff @(posedge iclk) begin
    if (reset) begin
      cnt      <= '0;
      wr_bank  <= 1'b0;
      in_blk   <= 1'b0;
      bank_evt <= '0;
    end else begin
      bank_evt.done <= blk_last;                              // One cycle after last write
      bank_evt.bank <= wr_bank;                               // Bank just finished
      if (in_sym.val) begin
        cnt <= blk_last ? '0 : waddr + 1'b1;                  // Wrap at block size
        if (blk_last) begin
          wr_bank <= ~wr_bank;                                // Next block to other bank
        end
        if (in_sym.sop) begin
          in_blk <= 1'b1;
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write request
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    wr_cmd.wr   = in_sym.val;                                 // Write on accept edge
    wr_cmd.bank = wr_bank;
    wr_cmd.addr = cAW'(waddr);                                // Row-major = arrival order
    wr_cmd.data = in_sym.data;
  end

  // First symbol after reset has to open a block with sop
  a_first_sop : assert property (
    @(posedge iclk) disable iff (reset)
    (in_sym.val && !in_blk) |-> in_sym.sop
  ) else $error("symbol accepted before any sop");

endmodule

// ==== logic/intl_read_ctrl.sv ====
// Column-major reader; banks are read strictly in fill order, overrun is not handled
`timescale 1ns/100ps

module intl_read_ctrl #(
  parameter int pROWS = 8,                            // Rows per block
  parameter int pCOLS = 16                            // Columns per block
) (
  input  logic                            iclk,
  input  logic                            reset,
  input  codec_intl_types_pkg::bank_evt_t bank_evt,   // Block filled
  output codec_intl_types_pkg::rd_cmd_t   rd_cmd      // Memory read request
);

  localparam int cAW    = codec_intl_cfg_pkg::cMAX_ADDR_W;
  localparam int cROW_W = (pROWS > 1) ? $clog2(pROWS) : 1;
  localparam int cCOL_W = (pCOLS > 1) ? $clog2(pCOLS) : 1;

  codec_intl_types_pkg::rd_state_t state;

  logic [1:0]        full;       // Bank holds an unread block
  logic [1:0]        pend;       // full plus this cycle's done
  logic              rd_ptr;     // Oldest bank, next to read
  logic [cROW_W-1:0] row;        // Row of current read
  logic [cCOL_W-1:0] col;        // Column of current read
  logic              row_last;
  logic              col_last;
  logic              burst;      // Read issued this cycle
  logic              burst_end;  // Last read of the block

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bank bookkeeping
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    pend = full;
    if (bank_evt.done) begin
      pend[bank_evt.bank] = 1'b1;                     // Seen before it lands in full
    end
  end

  assign row_last  = (row == cROW_W'(pROWS - 1));
  assign col_last  = (col == cCOL_W'(pCOLS - 1));
  assign burst     = (state == codec_intl_types_pkg::RD_BURST);
  assign burst_end = burst & row_last & col_last;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Scheduler and address counters
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge iclk) begin
    if (reset) begin
      state  <= codec_intl_types_pkg::RD_IDLE;
      full   <= '0;                                   // Both banks empty
      rd_ptr <= 1'b0;
      row    <= '0;
      col    <= '0;
    end else begin
      full <= pend;
      if (burst_end) begin
        full[rd_ptr] <= 1'b0;                         // Bank drained
      end
      case (state)
        codec_intl_types_pkg::RD_IDLE: begin
          if (pend[rd_ptr]) begin
            state <= codec_intl_types_pkg::RD_BURST;  // Counters already at 0
          end
        end
        codec_intl_types_pkg::RD_BURST: begin
          if (row_last) begin                         // Column done, step right
            row <= '0;
            col <= col_last ? '0 : col + 1'b1;
          end else begin
            row <= row + 1'b1;                        // Walk down the column
          end
          if (burst_end) begin
            rd_ptr <= ~rd_ptr;
            if (!pend[~rd_ptr]) begin
              state <= codec_intl_types_pkg::RD_IDLE; // Else chain the next burst
            end
          end
        end
        default: state <= codec_intl_types_pkg::RD_IDLE;
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read request
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    rd_cmd.rd   = burst;
    rd_cmd.bank = rd_ptr;
    rd_cmd.addr = cAW'(row) * cAW'(pCOLS) + cAW'(col);  // row * pCOLS + col
    rd_cmd.sop  = burst & (row == '0) & (col == '0);
    rd_cmd.eop  = burst_end;
  end

  // The write side may not finish a bank that has not been read yet
  a_no_overrun : assert property (
    @(posedge iclk) disable iff (reset)
    bank_evt.done |-> !full[bank_evt.bank]
  ) else $error("block done for bank %0d still pending", bank_evt.bank);

endmodule

// ==== logic/intl_pingpong_buf.sv ====
// Two-bank buffer; output flags lag rd_cmd by 1 + pPIPE cycles, data is valid only with val
`timescale 1ns/100ps

module intl_pingpong_buf #(
  parameter int pROWS = 8,                            // Rows per block
  parameter int pCOLS = 16,                           // Columns per block
  parameter bit pPIPE = 1                             // Memory output register
) (
  input  logic                            iclk,
  input  logic                            reset,
  input  codec_intl_types_pkg::wr_cmd_t   wr_cmd,     // From write controller
  input  codec_intl_types_pkg::rd_cmd_t   rd_cmd,     // From read controller
  output codec_intl_types_pkg::intl_sym_t out_sym     // Interleaved stream
);

  localparam int cSYM_W  = codec_intl_cfg_pkg::cSYM_W;
  localparam int cBLK    = pROWS * pCOLS;
  localparam int cADDR_W = (cBLK > 1) ? $clog2(cBLK) : 1;
  localparam int cDLY    = 1 + int'(pPIPE);           // Memory read latency

  logic [cSYM_W-1:0] bank_rdat [2];  // Read data per bank
  logic [cDLY-1:0]   vld_dly;        // Strobe delay line
  logic [cDLY-1:0]   sop_dly;
  logic [cDLY-1:0]   eop_dly;
  logic [cDLY-1:0]   sel_dly;        // Bank select delay line

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Memory banks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar b = 0; b < 2; b++) begin : g_bank
    codec_mem_block #(
      .pADDR_W (cADDR_W),
      .pDAT_W  (cSYM_W),
      .pPIPE   (pPIPE)
    ) u_mem (
      .iclk   (iclk),
      .reset  (reset),
      .clkena (1'b1),                                          // Always running
      .write  (wr_cmd.wr & (wr_cmd.bank == 1'(b))),            // Only selected bank
      .waddr  (wr_cmd.addr[cADDR_W-1:0]),
      .wdat   (wr_cmd.data),
      .raddr  (rd_cmd.addr[cADDR_W-1:0]),                      // Shared by both banks
      .rdat   (bank_rdat[b])
    );
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Flag alignment
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge iclk) begin
    if (reset) begin
      vld_dly <= '0;
      sop_dly <= '0;
      eop_dly <= '0;
    end else begin
      vld_dly[0] <= rd_cmd.rd;
      sop_dly[0] <= rd_cmd.sop;
      eop_dly[0] <= rd_cmd.eop;
      for (int i = 1; i < cDLY; i++) begin                    // Extra stage with pPIPE
        vld_dly[i] <= vld_dly[i-1];
        sop_dly[i] <= sop_dly[i-1];
        eop_dly[i] <= eop_dly[i-1];
      end
    end
  end

  always_ff @(posedge iclk) begin
    sel_dly[0] <= rd_cmd.bank;
    for (int i = 1; i < cDLY; i++) begin
      sel_dly[i] <= sel_dly[i-1];
    end
  end

  always_comb begin
    out_sym.val  = vld_dly[cDLY-1];
    out_sym.sop  = sop_dly[cDLY-1];
    out_sym.eop  = eop_dly[cDLY-1];
    out_sym.data = bank_rdat[sel_dly[cDLY-1]];                // Bank that was read
  end

  // Controllers may share a bank for one cycle at a block boundary, never a slot
  a_no_collision : assert property (
    @(posedge iclk) disable iff (reset)
    (wr_cmd.wr && rd_cmd.rd && (wr_cmd.bank == rd_cmd.bank)) |-> (wr_cmd.addr != rd_cmd.addr)
  ) else $error("read and write hit bank %0d slot %0d", rd_cmd.bank, rd_cmd.addr);

endmodule

// ==== logic/codec_block_intl.sv ====
// Block interleaver top; no back-pressure, a third block must not start before the first is read
`timescale 1ns/100ps

module codec_block_intl #(
  parameter int pROWS = codec_intl_cfg_pkg::cDEF_ROWS,  // Rows per block
  parameter int pCOLS = codec_intl_cfg_pkg::cDEF_COLS,  // Columns per block
  parameter bit pPIPE = 1                               // Memory output register
) (
  input  logic                            iclk,
  input  logic                            reset,
  input  codec_intl_types_pkg::intl_sym_t in_sym,       // Row-major input
  output codec_intl_types_pkg::intl_sym_t out_sym       // Column-major output
);

  codec_intl_types_pkg::wr_cmd_t   wr_cmd;    // Write side to buffer
  codec_intl_types_pkg::bank_evt_t bank_evt;  // Filled bank handoff
  codec_intl_types_pkg::rd_cmd_t   rd_cmd;    // Read side to buffer

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Controllers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  intl_write_ctrl #(
    .pROWS (pROWS),
    .pCOLS (pCOLS)
  ) u_write_ctrl (
    .iclk     (iclk),
    .reset    (reset),
    .in_sym   (in_sym),
    .wr_cmd   (wr_cmd),
    .bank_evt (bank_evt)
  );

  intl_read_ctrl #(
    .pROWS (pROWS),
    .pCOLS (pCOLS)
  ) u_read_ctrl (
    .iclk     (iclk),
    .reset    (reset),
    .bank_evt (bank_evt),       // Starts a burst one cycle later
    .rd_cmd   (rd_cmd)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Ping-pong storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  intl_pingpong_buf #(
    .pROWS (pROWS),
    .pCOLS (pCOLS),
    .pPIPE (pPIPE)
  ) u_buf (
    .iclk    (iclk),
    .reset   (reset),
    .wr_cmd  (wr_cmd),
    .rd_cmd  (rd_cmd),
    .out_sym (out_sym)          // 3 + pPIPE cycles after last input
  );

endmodule

// ==== tb/codec_block_intl_tb.sv ====
// Directed testbench for a 4 x 6 block with pPIPE set; output edges are taken at rising iclk
`timescale 1ns/100ps

module codec_block_intl_tb;

  localparam int cROWS   = 4;                          // Geometry under test
  localparam int cCOLS   = 6;
  localparam bit cPIPE   = 1;
  localparam int cBLK    = cROWS * cCOLS;              // Symbols per block
  localparam int cSW     = codec_intl_cfg_pkg::cSYM_W;
  localparam int cPERIOD = 4;                          // Clock period in ns
  localparam int cLAT    = 3 + int'(cPIPE);            // Last input edge to first output edge
  localparam int cSYMS   = (cBLK - 1) + cBLK + 3 * cBLK + (cBLK / 2 + cBLK) + 5 * cBLK;

  typedef logic [cSW-1:0] blk_t [cBLK];                // One block in arrival order

  logic                            iclk;
  logic                            reset;
  codec_intl_types_pkg::intl_sym_t in_sym;
  codec_intl_types_pkg::intl_sym_t out_sym;

  int                              cyc;               // Rising edges so far
  int                              last_in_edge;      // Edge that took the newest input
  int                              errors;
  logic [cSW-1:0]                  exp_q [$];         // Model output order
  codec_intl_types_pkg::intl_sym_t out_q [$];         // Collected output symbols
  int                              edge_q [$];        // Edge of each output symbol

  codec_block_intl #(
    .pROWS (cROWS),
    .pCOLS (cCOLS),
    .pPIPE (cPIPE)
  ) DUT (
    .iclk    (iclk),
    .reset   (reset),
    .in_sym  (in_sym),
    .out_sym (out_sym)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Clock, monitor, watchdog
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always #(cPERIOD / 2) iclk = ~iclk;

  always @(posedge iclk) begin
    cyc = cyc + 1;                                     // Values read here are pre-edge
    if (!reset && out_sym.val) begin
      out_q.push_back(out_sym);
      edge_q.push_back(cyc);
    end
  end

  initial begin
    #((cSYMS * 3 + 200) * cPERIOD);                    // Budget from total symbols sent
    $display("Timeout: the tests did not finish within %0d cycles", cyc);
    $display("test failed");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus and reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic blk_t count_block(input int base);
    blk_t b;
    for (int i = 0; i < cBLK; i++) begin
      b[i] = cSW'(base + i);                           // Counting payload
    end
    return b;
  endfunction

  function automatic blk_t random_block();
    blk_t b;
    for (int i = 0; i < cBLK; i++) begin
      b[i] = cSW'($urandom());
    end
    return b;
  endfunction

  task automatic drive_sym(input logic sop, input logic eop, input logic [cSW-1:0] data);
    @(posedge iclk);
    #1;
    in_sym.val   = 1'b1;
    in_sym.sop   = sop;
    in_sym.eop   = eop;
    in_sym.data  = data;
    last_in_edge = cyc + 1;                            // Taken on the coming edge
  endtask

  task automatic drive_idle(input int n);
    repeat (n) begin
      @(posedge iclk);
      #1;
      in_sym = '0;
    end
  endtask

  // Sends n_sent symbols of a block; only a full block is expected at the output
  task automatic send_block(input blk_t blk, input int max_gap, input int n_sent);
    for (int i = 0; i < n_sent; i++) begin
      if (max_gap > 0 && i > 0) begin
        drive_idle(int'($urandom_range(max_gap, 0)));  // Random idle gap
      end
      drive_sym(i == 0, i == cBLK - 1, blk[i]);
    end
    if (n_sent == cBLK) begin
      for (int c = 0; c < cCOLS; c++) begin            // Input r*COLS+c lands at c*ROWS+r
        for (int r = 0; r < cROWS; r++) begin
          exp_q.push_back(blk[r * cCOLS + c]);
        end
      end
    end
  endtask

  task automatic check_output(input string name, input bit check_lat);
    int waited;
    int n;
    waited = 0;
    while (out_q.size() < exp_q.size() && waited < 4 * cBLK + 50) begin
      @(posedge iclk);
      waited++;
    end
    repeat (cBLK) @(posedge iclk);                     // Catch stray symbols
    assert (out_q.size() == exp_q.size()) else begin
      errors++;
      $display("Fail %0t: %s got %0d symbols, expected %0d", $time, name,
               out_q.size(), exp_q.size());
    end
    if (check_lat && out_q.size() > 0) begin
      assert (edge_q[0] - last_in_edge == cLAT) else begin
        errors++;
        $display("Fail %0t: %s latency %0d, expected %0d", $time, name,
                 edge_q[0] - last_in_edge, cLAT);
      end
    end
    n = (out_q.size() < exp_q.size()) ? out_q.size() : exp_q.size();
    for (int i = 0; i < n; i++) begin
      assert (out_q[i].data == exp_q[i]) else begin
        errors++;
        $display("Fail %0t: %s symbol %0d data %h, expected %h", $time, name, i,
                 out_q[i].data, exp_q[i]);
      end
      assert (out_q[i].sop == (i % cBLK == 0) && out_q[i].eop == (i % cBLK == cBLK - 1))
      else begin
        errors++;
        $display("Fail %0t: %s symbol %0d has sop %b eop %b", $time, name, i,
                 out_q[i].sop, out_q[i].eop);
      end
      if (i % cBLK != 0) begin
        assert (edge_q[i] == edge_q[i-1] + 1) else begin
          errors++;
          $display("Fail %0t: %s gap in burst before symbol %0d", $time, name, i);
        end
      end
    end
    out_q.delete();
    edge_q.delete();
    exp_q.delete();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic test_quiet_after_reset();
    send_block(count_block(8'h10), 0, cBLK - 1);       // One short of a block
    drive_idle(cBLK);
    assert (out_q.size() == 0) else begin
      errors++;
      $display("Fail %0t: output before a full block, %0d symbols", $time, out_q.size());
    end
    out_q.delete();
    edge_q.delete();
  endtask

  task automatic test_single_block();
    send_block(count_block(8'h40), 0, cBLK);
    drive_idle(1);
    check_output("single block", 1'b1);
  endtask

  task automatic test_back_to_back();
    send_block(count_block(8'h80), 0, cBLK);           // Gapless, fills both banks
    send_block(count_block(8'h98), 0, cBLK);
    send_block(count_block(8'hb0), 0, cBLK);
    drive_idle(1);
    check_output("back to back", 1'b0);
  endtask

  task automatic test_sop_restart();
    send_block(count_block(8'h20), 0, cBLK / 2);       // Dropped by the next sop
    send_block(count_block(8'hc0), 0, cBLK);
    drive_idle(1);
    check_output("sop restart", 1'b0);
  endtask

  task automatic test_random_gaps();
    for (int b = 0; b < 5; b++) begin
      send_block(random_block(), 2, cBLK);
    end
    drive_idle(1);
    check_output("random gaps", 1'b0);
  endtask

  initial begin
    iclk         = 1'b0;
    reset        = 1'b1;
    in_sym       = '0;
    cyc          = 0;
    last_in_edge = 0;
    errors       = 0;
    void'($urandom(32'hf73c_c741));                    // Single seed for the run
    repeat (10) @(posedge iclk);
    #1;
    reset = 1'b0;
    test_quiet_after_reset();
    test_single_block();
    test_back_to_back();
    test_sop_restart();
    test_random_gaps();
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
logic/codec_intl_cfg_pkg.sv
logic/codec_intl_types_pkg.sv
logic/codec_mem_block.sv
logic/intl_write_ctrl.sv
logic/intl_read_ctrl.sv
logic/intl_pingpong_buf.sv
logic/codec_block_intl.sv
tb/codec_block_intl_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := codec_block_intl_tb
FILELIST := filelist.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST))
PASS_MSG := test passed

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The log decides the result, not the simulator exit status
run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
